// ==== nocPkg.sv ====
package nocPkg;

  ////////////////////////////////////////////////////////////
  // sizes.

  localparam int numPorts    = 5;
  localparam int lengthWidth = 12; // length field and timer count.

  ////////////////////////////////////////////////////////////
  // encodings.

  // one-hot flit kind.
  typedef enum logic [2:0] {
    kindHeader = 3'b001,
    kindBody   = 3'b010,
    kindTail   = 3'b100
  } flitKindT;

  typedef enum logic [2:0] {
    portL,
    portN,
    portE,
    portW,
    portS
  } portIdT;

  // arbiter state with bit p+1 naming port p.
  typedef enum logic [5:0] {
    grantIdle = 6'b000001,
    grantL    = 6'b000010,
    grantN    = 6'b000100,
    grantE    = 6'b001000,
    grantW    = 6'b010000,
    grantS    = 6'b100000
  } grantT;

  ////////////////////////////////////////////////////////////
  // flits.

  typedef struct packed {
    flitKindT               kind;
    logic [lengthWidth-1:0] payload; // cycles of hold in a header.
  } flitT;

  typedef struct packed {
    portIdT src;
    flitT   flit;
  } outFlitT;

endpackage

// ==== inputPort.sv ====
`timescale 1ns/1ps

module inputPort (
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  input  nocPkg::flitT inFlit,
  input  logic         full,
  output logic         wrEn,
  output nocPkg::flitT wrFlit,
  output logic [7:0]   dropCount
);
  import nocPkg::*;

  logic inPacket; // accepted header seen, tail not yet.
  logic framed;
  logic drop;

  ////////////////////////////////////////////////////////////
  // framing check.

  always_comb
  begin
    if (inPacket)
      framed = (inFlit.kind == kindBody) || (inFlit.kind == kindTail);
    else
      framed = (inFlit.kind == kindHeader);
  end

  // write at the strobe edge.
  assign wrEn   = inValid && framed && !full;
  assign wrFlit = inFlit;
  assign drop   = inValid && !wrEn; // one pulse per lost flit.

  // packet state follows accepted flits only.
  always_ff @(posedge clk)
  begin
    if (rst)
      inPacket <= 1'b0;
    else if (wrEn)
    begin
      if (inFlit.kind == kindHeader)
        inPacket <= 1'b1;
      else if (inFlit.kind == kindTail)
        inPacket <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // drop counter.

  always_ff @(posedge clk)
  begin
    if (rst)
      dropCount <= '0;
    else if (drop && (dropCount != 8'hff)) // saturates.
      dropCount <= dropCount + 8'd1;
  end

endmodule

// ==== flitFifo.sv ====
`timescale 1ns/1ps

module flitFifo #(
  parameter int fifoDepth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         wrEn,
  input  nocPkg::flitT wrFlit,
  input  logic         rdEn,
  output nocPkg::flitT head,
  output logic         empty,
  output logic         full
);
  import nocPkg::*;

  localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntWidth = ptrWidth + 1;

  flitT                mem [fifoDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;
  logic                doWrite;
  logic                doRead;

  // wrap at the last slot.
  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(fifoDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign doWrite = wrEn && !full;
  assign doRead  = rdEn && !empty;

  assign empty = (count == '0);
  assign full  = (count == cntWidth'(fifoDepth));
  assign head  = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= wrFlit;
  end

  ////////////////////////////////////////////////////////////
  // pointers and level.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doRead)
        rdPtr <= nextPtr(rdPtr);
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither.
      endcase
    end
  end

endmodule

// ==== holdTimer.sv ====
`timescale 1ns/1ps

module holdTimer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           popHeader,
  input  logic [nocPkg::lengthWidth-1:0] length,
  input  logic                           run,
  output logic                           timesUp
);
  import nocPkg::*;

  logic [lengthWidth-1:0] limit; // from the last popped header.
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (popHeader)
        limit <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0; // restart once the hold ends.
    end
  end

  assign timesUp = (count == limit);

endmodule

// ==== outputArbiter.sv ====
`timescale 1ns/1ps

module outputArbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic         [nocPkg::numPorts-1:0] req,
  input  logic         [nocPkg::numPorts-1:0] pop,
  input  nocPkg::flitT [nocPkg::numPorts-1:0] headFlit,
  output nocPkg::grantT                        grant
);
  import nocPkg::*;

  grantT               nextGrant;
  portIdT              holder;
  logic [numPorts-1:0] run;
  logic [numPorts-1:0] timesUp;

  // first requester from port start within span ports.
  function automatic grantT firstReq(
    input logic [numPorts-1:0] r,
    input int                  start,
    input int                  span
  );
    grantT pick;
    int    idx;
    pick = grantIdle;
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if ((k < span) && r[idx])
        pick = grantT'(6'b000010 << idx); // earliest one wins.
    end
    return pick;
  endfunction

  ////////////////////////////////////////////////////////////
  // hold timers.

  for (genvar p = 0; p < numPorts; p++)
  begin : timerGen
    holdTimer holdTimer_inst (
      .clk       (clk),
      .rst       (rst),
      .popHeader (pop[p] && (headFlit[p].kind == kindHeader)),
      .length    (headFlit[p].payload),
      .run       (run[p]),
      .timesUp   (timesUp[p])
    );
  end

  ////////////////////////////////////////////////////////////
  // grant state machine.

  always_comb
  begin
    holder = portL;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p + 1])
        holder = portIdT'(p);
    end
  end

  always_comb
  begin
    run       = '0;
    nextGrant = grant;
    case (grant)
      grantIdle:
        nextGrant = firstReq(req, int'(portL), numPorts); // fixed L, N, E, W, S.
      grantL, grantN, grantE, grantW, grantS:
      begin
        // west holds like every other port.
        if (req[holder] && !timesUp[holder])
        begin
          run[holder] = 1'b1;
          nextGrant   = grant;
        end
        else
        begin
          // rotate past the holder or go idle.
          nextGrant = firstReq(req, int'(holder) + 1, numPorts - 1);
        end
      end
      default:
        nextGrant = grantIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= grantIdle;
    else
      grant <= nextGrant;
  end

endmodule

// ==== outputSwitch.sv ====
`timescale 1ns/1ps

module outputSwitch (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocPkg::grantT                        grant,
  input  logic         [nocPkg::numPorts-1:0] empty,
  input  nocPkg::flitT [nocPkg::numPorts-1:0] heads,
  output logic         [nocPkg::numPorts-1:0] pop,
  output logic                                 outValid,
  output nocPkg::outFlitT                      outFlit
);
  import nocPkg::*;

  outFlitT selFlit;

  ////////////////////////////////////////////////////////////
  // grant decode and head select.

  always_comb
  begin
    pop          = '0;
    selFlit.src  = portL;
    selFlit.flit = heads[0];
    for (int p = 0; p < numPorts; p++)
    begin
      pop[p] = grant[p + 1] && !empty[p];
      if (grant[p + 1])
      begin
        selFlit.src  = portIdT'(p);
        selFlit.flit = heads[p];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output register.

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop; // one cycle after the pop.
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
      outFlit <= selFlit;
  end

endmodule

// ==== routerOutput.sv ====
`timescale 1ns/1ps

module routerOutput #(
  parameter int fifoDepth = 4
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic         [nocPkg::numPorts-1:0] inValid,
  input  nocPkg::flitT [nocPkg::numPorts-1:0] inFlit,
  output logic                                 outValid,
  output nocPkg::outFlitT                      outFlit,
  output logic [nocPkg::numPorts-1:0][7:0]    dropCount
);
  import nocPkg::*;

  logic  [numPorts-1:0] wrEn;
  flitT  [numPorts-1:0] wrFlit;
  logic  [numPorts-1:0] full;
  logic  [numPorts-1:0] empty;
  flitT  [numPorts-1:0] heads;
  logic  [numPorts-1:0] pop;
  grantT                grant;

  ////////////////////////////////////////////////////////////
  // per-port input stage and buffer.

  for (genvar p = 0; p < numPorts; p++)
  begin : portGen
    inputPort inputPort_inst (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[p]),
      .inFlit    (inFlit[p]),
      .full      (full[p]),
      .wrEn      (wrEn[p]),
      .wrFlit    (wrFlit[p]),
      .dropCount (dropCount[p])
    );

    flitFifo #(
      .fifoDepth (fifoDepth)
    ) flitFifo_inst (
      .clk    (clk),
      .rst    (rst),
      .wrEn   (wrEn[p]),
      .wrFlit (wrFlit[p]),
      .rdEn   (pop[p]),
      .head   (heads[p]),
      .empty  (empty[p]),
      .full   (full[p])
    );
  end

  ////////////////////////////////////////////////////////////
  // arbitration and output.

  outputArbiter outputArbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (~empty), // a port requests while it holds flits.
    .pop      (pop),
    .headFlit (heads),
    .grant    (grant)
  );

  outputSwitch outputSwitch_inst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .empty    (empty),
    .heads    (heads),
    .pop      (pop),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

endmodule

// ==== routerOutput_properties.sv ====
`timescale 1ns/1ps

module routerOutput_properties (
  input logic                          clk,
  input logic                          rst,
  input nocPkg::grantT                 grant,
  input logic [nocPkg::numPorts-1:0] empty,
  input logic [nocPkg::numPorts-1:0] pop,
  input logic                          outValid
);
  import nocPkg::*;

  ////////////////////////////////////////////////////////////
  // grant and output rules.

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot");

  // output register only loads after a pop.
  validAfterPop: assert property (@(posedge clk) disable iff (rst) outValid |-> $past(|pop))
    else $error("outValid without a pop in the previous cycle");

  for (genvar p = 0; p < numPorts; p++)
  begin : emptyGen
    noGrantWhenEmpty: assert property (@(posedge clk) disable iff (rst)
      $past(empty[p]) |-> !grant[p + 1])
      else $error("grant names port %0d whose buffer was empty", p);
  end

endmodule

bind routerOutput routerOutput_properties routerOutputProps (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .empty    (empty),
  .pop      (pop),
  .outValid (outValid)
);

// ==== tbRouterOutput.sv ====
`timescale 1ns/1ps

module tbRouterOutput;
  import nocPkg::*;

  typedef struct {
    int                     sec;
    int                     cycle; // edges after the previous row, 0 is the same edge.
    portIdT                 port;
    flitKindT               kind;
    logic [lengthWidth-1:0] payload;
    bit                     drop;
  } rowT;

  logic                     clk;
  logic                     rst;
  logic [numPorts-1:0]      inValid;
  flitT [numPorts-1:0]      inFlit;
  logic                     outValid;
  outFlitT                  outFlit;
  logic [numPorts-1:0][7:0] dropCount;

  rowT         rows[$];
  flitT        expQ[numPorts][$]; // reference model with one queue per port.
  portIdT      srcLog[$];
  time         timeLog[$];
  int          secStart[5];
  int          dropExp[numPorts];
  time         firstStrobe;
  logic [31:0] lfsr;
  bit          tableReady;

  routerOutput #(
    .fifoDepth (4)
  ) routerOutput_inst (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .dropCount (dropCount)
  );

  initial
    clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic reportStray(input portIdT src);
    $display("output flit tagged with port %0d arrived with nothing expected", src);
    $display("RESULT: FAIL");
    $fatal(1, "unexpected output flit");
  endtask

  task automatic addRow(input int sec, input int cycle, input portIdT port,
                        input flitKindT kind, input int payload, input bit drop);
    rowT r;
    r.sec     = sec;
    r.cycle   = cycle;
    r.port    = port;
    r.kind    = kind;
    r.payload = payload[lengthWidth-1:0];
    r.drop    = drop;
    rows.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table.

  task automatic fillTable();
    // single packet on an idle router.
    addRow(0, 1, portL, kindHeader, 3, 0);
    addRow(0, 1, portL, kindBody, 12'h011, 0);
    addRow(0, 1, portL, kindBody, 12'h012, 0);
    addRow(0, 1, portL, kindTail, 12'h013, 0);
    // framing errors on north.
    addRow(1, 1, portN, kindBody, 12'h0e1, 1);
    addRow(1, 1, portN, kindTail, 12'h0e2, 1);
    addRow(1, 1, portN, kindHeader, 2, 0);
    addRow(1, 1, portN, kindHeader, 5, 1); // header inside open packet.
    addRow(1, 1, portN, kindBody, 12'h021, 0);
    addRow(1, 1, portN, kindTail, 12'h022, 0);
    // L holds the channel while S overflows.
    addRow(2, 1, portL, kindHeader, 20, 0);
    addRow(2, 1, portL, kindBody, 12'h101, 0);
    addRow(2, 1, portL, kindBody, 12'h102, 0);
    addRow(2, 0, portS, kindHeader, 2, 0);
    addRow(2, 1, portL, kindBody, 12'h103, 0);
    addRow(2, 0, portS, kindBody, 12'h501, 0);
    addRow(2, 1, portL, kindBody, 12'h104, 0);
    addRow(2, 0, portS, kindBody, 12'h502, 0);
    addRow(2, 1, portL, kindBody, 12'h105, 0);
    addRow(2, 0, portS, kindBody, 12'h503, 0);
    addRow(2, 1, portL, kindBody, 12'h106, 0);
    addRow(2, 0, portS, kindBody, 12'h5e4, 1); // buffer full.
    addRow(2, 1, portL, kindBody, 12'h107, 0);
    addRow(2, 0, portS, kindTail, 12'h5e5, 1);
    addRow(2, 1, portL, kindBody, 12'h108, 0);
    addRow(2, 1, portL, kindTail, 12'h109, 0);
    // fixed priority from idle.
    addRow(3, 1, portN, kindHeader, 4, 0);
    addRow(3, 0, portW, kindHeader, 4, 0);
    addRow(3, 0, portS, kindTail, 12'h506, 0);
    addRow(3, 1, portN, kindTail, 12'h031, 0);
    addRow(3, 0, portW, kindTail, 12'h041, 0);
    // short hold on east and then rotation.
    addRow(4, 1, portE, kindHeader, 1, 0);
    addRow(4, 1, portL, kindHeader, 2, 0);
    addRow(4, 0, portS, kindHeader, 2, 0);
    addRow(4, 1, portE, kindBody, 12'h301, 0);
    addRow(4, 0, portL, kindTail, 12'h111, 0);
    addRow(4, 0, portS, kindTail, 12'h511, 0);
    addRow(4, 1, portE, kindTail, 12'h302, 0);
  endtask

  function automatic bit queuesEmpty();
    for (int p = 0; p < numPorts; p++)
    begin
      if (expQ[p].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // idle inputs and wait for the output to catch up and the grant to settle.
  task automatic drain();
    @(posedge clk);
    inValid <= '0;
    while (!queuesEmpty())
      @(negedge clk);
    repeat (3) @(posedge clk);
  endtask

  task automatic randomGap();
    int gap;
    gap = 0;
    repeat (2)
    begin
      lfsr = lfsrStep(lfsr);
      gap  = gap * 2 + lfsr[0];
    end
    repeat (gap) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor.

  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      if (expQ[int'(outFlit.src)].size() == 0)
        reportStray(outFlit.src);
      else
        checkValue("outFlit.flit", outFlit.flit, expQ[int'(outFlit.src)].pop_front());
      srcLog.push_back(outFlit.src);
      timeLog.push_back($time);
    end
  end

  initial
  begin
    wait (tableReady);
    repeat (rows.size() * 20) @(posedge clk);
    $display("watchdog expired before the test finished");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial
  begin
    int                  idx;
    int                  p;
    logic [numPorts-1:0] vec;
    flitT [numPorts-1:0] flits;
    rst        = 1'b1;
    inValid    = '0;
    inFlit     = '0;
    lfsr       = 32'h9156;
    tableReady = 1'b0;
    fillTable();
    tableReady = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    idx = 0;
    while (idx < rows.size())
    begin
      if ((idx == 0) || (rows[idx].sec != rows[idx - 1].sec))
      begin
        drain();
        randomGap();
        secStart[rows[idx].sec] = srcLog.size();
      end
      for (int k = 1; k <= rows[idx].cycle; k++)
      begin
        @(posedge clk);
        if (k < rows[idx].cycle)
          inValid <= '0;
      end
      if (idx == 0)
        firstStrobe = $time;
      vec   = '0;
      flits = '0;
      do
      begin
        p                = int'(rows[idx].port);
        vec[p]           = 1'b1;
        flits[p].kind    = rows[idx].kind;
        flits[p].payload = rows[idx].payload;
        if (rows[idx].drop)
          dropExp[p]++;
        else
          expQ[p].push_back(flits[p]);
        idx++;
      end
      while ((idx < rows.size()) && (rows[idx].cycle == 0));
      inValid <= vec;
      inFlit  <= flits;
    end
    drain();

    // idle latency of the first flit sampled half a cycle late.
    checkValue("first output delay", timeLog[0] - firstStrobe, 350);
    checkValue("first src after common fill", srcLog[secStart[3]], portN);
    checkValue("src before timer expiry", srcLog[secStart[4]], portE);
    checkValue("src after rotation", srcLog[secStart[4] + 1], portS);
    for (int q = 0; q < numPorts; q++)
      checkValue($sformatf("dropCount[%0d]", q), dropCount[q], dropExp[q]);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== project.f ====
nocPkg.sv
inputPort.sv
flitFifo.sv
holdTimer.sv
outputArbiter.sv
outputSwitch.sv
routerOutput.sv
routerOutput_properties.sv
tbRouterOutput.sv
